// ==== filelist.f ====
+incdir+.
player_pkg.sv
player_input_decode.sv
player_motion.sv
player_status.sv
player_sprite_render.sv
sprite_rom.sv
player_top.sv
tb_player_checks.sv
tb_player_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_player_top
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sprite_idle.hex ====
// 8 bytes per line, one line per sprite row, byte = row*16 + column
00 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47
50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67
70 71 72 73 74 75 76 77
80 81 82 83 84 85 86 87
90 91 92 93 94 95 96 97
a0 a1 a2 a3 a4 a5 a6 a7
b0 b1 b2 b3 b4 b5 b6 b7

// ==== sprite_run.hex ====
// 8 bytes per line, one line per sprite row, byte = 0x80 + row*16 + column (8 bits)
80 81 82 83 84 85 86 87
90 91 92 93 94 95 96 97
a0 a1 a2 a3 a4 a5 a6 a7
b0 b1 b2 b3 b4 b5 b6 b7
c0 c1 c2 c3 c4 c5 c6 c7
d0 d1 d2 d3 d4 d5 d6 d7
e0 e1 e2 e3 e4 e5 e6 e7
f0 f1 f2 f3 f4 f5 f6 f7
00 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 34 35 36 37

// ==== tb_player_top.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module tb_player_top;

    localparam int FRAME_CYCLES = 40;
    // longest run is dominated by the clamp walk
    localparam int MAX_TICKS = 700;

    logic Clk = 1'b0;
    logic reset = 1'b1;
    logic frame_clk = 1'b0;
    logic revive, dead, key_jump, key_left, key_right, draw_valid;
    logic [9:0] draw_x, draw_y;
    player_pkg::hitbox_t hitbox;
    logic win, in_sprite;
    logic [`PIX_W-1:0] pixel;
    int frame_cnt;
    int check_errors, check_count;
    int seq_errors = 0;
    int test_num = 1;
    int prev_errors = 0;

    always #5 Clk = ~Clk;

    // frame clock high for half of each 40-cycle period
    always @(posedge Clk) begin
        if (reset) begin
            frame_cnt <= 0;
            frame_clk <= 1'b0;
        end else begin
            frame_cnt <= (frame_cnt == FRAME_CYCLES - 1) ? 0 : frame_cnt + 1;
            frame_clk <= (frame_cnt < FRAME_CYCLES / 2);
        end
    end

    player_top player_top_inst (
        .Clk(Clk), .reset(reset), .frame_clk(frame_clk), .revive(revive), .dead(dead),
        .key_jump(key_jump), .key_left(key_left), .key_right(key_right),
        .draw_x(draw_x), .draw_y(draw_y), .hitbox(hitbox), .win(win),
        .in_sprite(in_sprite), .pixel(pixel)
    );

    tb_player_checks checks_inst (
        .Clk(Clk), .reset(reset), .frame_clk(frame_clk), .revive(revive), .dead(dead),
        .key_jump(key_jump), .key_left(key_left), .key_right(key_right),
        .draw_x(draw_x), .draw_y(draw_y), .draw_valid(draw_valid), .hitbox(hitbox),
        .win(win), .in_sprite(in_sprite), .pixel(pixel),
        .errors(check_errors), .checks(check_count)
    );

    initial begin
        #((MAX_TICKS * FRAME_CYCLES + 100) * 10);
        $display("watchdog expired after %0d frame ticks", MAX_TICKS);
        $display("Test FAILED");
        $finish;
    end

    // returns just after a frame fall with the state already updated
    task automatic wait_ticks(input int n);
        repeat (n) @(negedge frame_clk);
        @(posedge Clk);
    endtask

    task automatic set_keys(input logic j, input logic l, input logic r);
        key_jump  <= j;
        key_left  <= l;
        key_right <= r;
    endtask

    task automatic pulse_revive();
        revive <= 1'b1;
        @(posedge Clk);
        revive <= 1'b0;
        @(posedge Clk);
    endtask

    task automatic expect_start_hitbox();
        player_pkg::hitbox_t exp;
        exp.top    = `START_Y + `INSET_TOP;
        exp.bottom = `START_Y + `SPRITE_H - `INSET_BOTTOM;
        exp.left   = `START_X + `INSET_SIDE;
        exp.right  = `START_X + `SPRITE_W - `INSET_SIDE;
        if (hitbox != exp) begin
            seq_errors++;
            $display("[FAIL] hitbox dut=%h exp=%h", hitbox, exp);
        end
    endtask

    // six points inside the box and two just outside
    task automatic present_points();
        player_pkg::pos_t bx, by;
        int r, c;
        bx = hitbox.left - `INSET_SIDE;
        by = hitbox.top - `INSET_TOP;
        for (int i = 0; i < 6; i++) begin
            r = int'($urandom % `SPRITE_H);
            c = int'($urandom % `SPRITE_W);
            draw_x     <= 10'(bx + c);
            draw_y     <= 10'(by + r);
            draw_valid <= 1'b1;
            @(posedge Clk);
        end
        draw_x <= 10'(bx + `SPRITE_W);
        draw_y <= 10'(by);
        @(posedge Clk);
        draw_x <= 10'(bx);
        draw_y <= 10'(by + `SPRITE_H);
        @(posedge Clk);
        draw_valid <= 1'b0;
        @(posedge Clk);
    endtask

    task automatic end_test(input string name);
        int total;
        total = check_errors + seq_errors;
        $display("test %0d %s: %s", test_num, name, (total == prev_errors) ? "pass" : "fail");
        prev_errors = total;
        test_num++;
    endtask

    initial begin
        int n, m, k;
        logic seen_win;
        player_pkg::hitbox_t held;
        void'($urandom(96931));
        revive = 1'b0;
        dead = 1'b0;
        key_jump = 1'b0;
        key_left = 1'b0;
        key_right = 1'b0;
        draw_x = '0;
        draw_y = '0;
        draw_valid = 1'b0;
        repeat (10) @(posedge Clk);
        reset <= 1'b0;

        // start point after reset
        wait_ticks(1);
        expect_start_hitbox();
        if (win) begin
            seq_errors++;
            $display("[FAIL] win dut=%h exp=%h", win, 1'b0);
        end
        end_test("reset");

        // walk right then left then into the right wall
        n = 5 + int'($urandom % 11);
        m = 5 + int'($urandom % 11);
        set_keys(0, 0, 1);
        wait_ticks(n);
        set_keys(0, 1, 0);
        wait_ticks(m);
        set_keys(0, 0, 1);
        k = 0;
        while (hitbox.left != `ARENA_X_MAX - `SPRITE_W + 2 * `INSET_SIDE - 1 && k < 400) begin
            wait_ticks(1);
            k++;
        end
        wait_ticks(2);
        if (hitbox.left != `ARENA_X_MAX - `SPRITE_W + 2 * `INSET_SIDE - 1) begin
            seq_errors++;
            $display("[FAIL] hitbox.left dut=%h exp=%h", hitbox.left,
                     16'(`ARENA_X_MAX - `SPRITE_W + 2 * `INSET_SIDE - 1));
        end
        end_test("walk");

        // walk across the exit square
        set_keys(0, 0, 0);
        pulse_revive();
        set_keys(0, 0, 1);
        seen_win = 1'b0;
        repeat (45) begin
            wait_ticks(1);
            if (win) seen_win = 1'b1;
        end
        if (!seen_win || win) begin
            seq_errors++;
            $display("win did not rise and fall while crossing the exit");
        end
        end_test("exit");

        // jump from the floor and land again
        set_keys(1, 0, 0);
        pulse_revive();
        wait_ticks(1);
        set_keys(0, 0, 0);
        if (hitbox.top >= `START_Y + `INSET_TOP) begin
            seq_errors++;
            $display("jump did not leave the floor");
        end
        k = 0;
        while (hitbox.top != `START_Y + `INSET_TOP && k < 150) begin
            wait_ticks(1);
            k++;
        end
        expect_start_hitbox();
        end_test("jump");

        // frozen while dead and revive restores the start
        set_keys(0, 0, 1);
        wait_ticks(3);
        dead <= 1'b1;
        set_keys(1, 0, 1);
        @(posedge Clk);
        held = hitbox;
        wait_ticks(5);
        if (hitbox != held) begin
            seq_errors++;
            $display("[FAIL] hitbox dut=%h exp=%h", hitbox, held);
        end
        pulse_revive();
        dead <= 1'b0;
        set_keys(0, 0, 0);
        wait_ticks(1);
        expect_start_hitbox();
        end_test("dead");

        // idle then run then mirrored run then mirrored idle
        present_points();
        set_keys(0, 0, 1);
        wait_ticks(1);
        present_points();
        set_keys(0, 1, 0);
        wait_ticks(1);
        present_points();
        set_keys(0, 0, 0);
        wait_ticks(1);
        present_points();
        wait_ticks(1);
        end_test("pixel");

        $display("tests %0d, checks %0d, errors %0d", test_num - 1,
                 check_count, check_errors + seq_errors);
        if (check_errors + seq_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_player_checks.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module tb_player_checks (
    input  logic                Clk,
    input  logic                reset,
    input  logic                frame_clk,
    input  logic                revive,
    input  logic                dead,
    input  logic                key_jump,
    input  logic                key_left,
    input  logic                key_right,
    input  logic [9:0]          draw_x,
    input  logic [9:0]          draw_y,
    input  logic                draw_valid,
    input  player_pkg::hitbox_t hitbox,
    input  logic                win,
    input  logic                in_sprite,
    input  logic [`PIX_W-1:0]   pixel,
    output int                  errors,
    output int                  checks
);

    // cycle after a frame rise where the state is compared
    localparam int SAMPLE_AT = 36;

    // reference model of the player
    player_pkg::pos_t mx, my, mvy;
    int               gcnt;
    logic             mgnd, mface, manim;
    logic             frame_d;
    int               since_rise;
    int               err_cnt = 0;
    int               chk_cnt = 0;
    // draw point seen by the DUT one cycle ago
    logic [9:0]       dx_q, dy_q;
    logic             dv_q;
    player_pkg::hitbox_t exp_hb;
    logic             exp_win, exp_in;
    logic [`PIX_W-1:0] exp_pix;
    int               off_x, off_y, col;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // one frame tick of the motion rules
    task automatic advance_model();
        player_pkg::pos_t nx, ny, nvx, nvy;
        logic ng;
        nvx = key_left ? -`WALK_SPEED : (key_right ? `WALK_SPEED : 0);
        nvy = mvy;
        ng  = mgnd;
        if (gcnt == `GRAVITY_DIV) begin
            gcnt <= 0;
            nvy = nvy + `GRAVITY_STEP;
        end else begin
            gcnt <= gcnt + 1;
        end
        if (key_jump && mgnd) begin
            nvy = `JUMP_V0;
            ng  = 1'b0;
        end
        nx = mx + nvx;
        ny = my + nvy;
        if (nx < `ARENA_X_MIN - `INSET_SIDE) nx = `ARENA_X_MIN - `INSET_SIDE;
        if (nx > `ARENA_X_MAX - `SPRITE_W - 1 + `INSET_SIDE) begin
            nx = `ARENA_X_MAX - `SPRITE_W - 1 + `INSET_SIDE;
        end
        if (ny < `ARENA_Y_MIN) begin
            ny  = `ARENA_Y_MIN;
            nvy = 0;
        end else if (ny + `SPRITE_H >= `ARENA_Y_MAX) begin
            ny  = `ARENA_Y_MAX - `SPRITE_H - 1;
            ng  = 1'b1;
            nvy = 0;
        end
        mx    <= nx;
        my    <= ny;
        mvy   <= nvy;
        mgnd  <= ng;
        manim <= (nvx != 0);
        if (nvx != 0) mface <= (nvx < 0);
    endtask

    always @(posedge Clk) begin
        frame_d <= frame_clk;
        dx_q    <= draw_x;
        dy_q    <= draw_y;
        dv_q    <= draw_valid && !reset;
        if (reset || (frame_clk && !frame_d)) begin
            since_rise <= 0;
        end else begin
            since_rise <= since_rise + 1;
        end
        if (!reset && since_rise == SAMPLE_AT) chk_cnt <= chk_cnt + 1;
        if (!reset && dv_q) chk_cnt <= chk_cnt + 1;
        // revive and reset both return to the start point
        if (reset || revive) begin
            mx    <= `START_X;
            my    <= `START_Y;
            mvy   <= 0;
            gcnt  <= 0;
            mgnd  <= 1'b1;
            mface <= 1'b0;
            manim <= 1'b0;
        end else if (frame_clk && !frame_d && !dead) begin
            advance_model();
        end
    end

    // expected outputs from the model
    always_comb begin
        exp_hb.top    = my + `INSET_TOP;
        exp_hb.bottom = my + `SPRITE_H - `INSET_BOTTOM;
        exp_hb.left   = mx + `INSET_SIDE;
        exp_hb.right  = mx + `SPRITE_W - `INSET_SIDE;
        exp_win = (exp_hb.right > `EXIT_X - `EXIT_RADIUS) &&
                  (exp_hb.left < `EXIT_X + `EXIT_RADIUS) &&
                  (exp_hb.bottom > `EXIT_Y - `EXIT_RADIUS) &&
                  (exp_hb.top < `EXIT_Y + `EXIT_RADIUS);
        off_x  = int'(dx_q) - int'(mx);
        off_y  = int'(dy_q) - int'(my);
        exp_in = (off_x >= 0) && (off_x < `SPRITE_W) && (off_y >= 0) && (off_y < `SPRITE_H);
        // mirrored column while facing left
        col     = mface ? (`SPRITE_W - 1 - off_x) : off_x;
        exp_pix = exp_in ? 8'((manim ? 128 : 0) + off_y * 16 + col) : 8'h00;
    end

    assert property (@(posedge Clk) disable iff (reset)
        (since_rise != SAMPLE_AT || hitbox == exp_hb))
    else begin
        err_cnt++;
        $display("[FAIL] hitbox dut=%h exp=%h", $sampled(hitbox), $sampled(exp_hb));
    end

    assert property (@(posedge Clk) disable iff (reset)
        (since_rise != SAMPLE_AT || win == exp_win))
    else begin
        err_cnt++;
        $display("[FAIL] win dut=%h exp=%h", $sampled(win), $sampled(exp_win));
    end

    assert property (@(posedge Clk) disable iff (reset) (!dv_q || in_sprite == exp_in))
    else begin
        err_cnt++;
        $display("[FAIL] in_sprite dut=%h exp=%h", $sampled(in_sprite), $sampled(exp_in));
    end

    assert property (@(posedge Clk) disable iff (reset) (!dv_q || pixel == exp_pix))
    else begin
        err_cnt++;
        $display("[FAIL] pixel dut=%h exp=%h", $sampled(pixel), $sampled(exp_pix));
    end

endmodule

// ==== player_top.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module player_top (
    input  logic                Clk,
    input  logic                reset,
    input  logic                frame_clk,
    input  logic                revive,
    input  logic                dead,
    input  logic                key_jump,
    input  logic                key_left,
    input  logic                key_right,
    input  logic [9:0]          draw_x,
    input  logic [9:0]          draw_y,
    output player_pkg::hitbox_t hitbox,
    output logic                win,
    output logic                in_sprite,
    output logic [`PIX_W-1:0]   pixel
);

    // decode to motion
    player_pkg::player_cmd_t   cmd;
    // motion to status and render
    player_pkg::motion_state_t state;
    // render to rom and back
    logic [`ROM_AW-1:0]        rom_addr;
    player_pkg::anim_t         bank;
    logic [`PIX_W-1:0]         rom_data;

    player_input_decode player_input_decode_inst (
        .Clk       (Clk),
        .reset     (reset),
        .frame_clk (frame_clk),
        .dead      (dead),
        .key_jump  (key_jump),
        .key_left  (key_left),
        .key_right (key_right),
        .cmd       (cmd)
    );

    player_motion player_motion_inst (
        .Clk    (Clk),
        .reset  (reset),
        .revive (revive),
        .dead   (dead),
        .cmd    (cmd),
        .state  (state)
    );

    player_status player_status_inst (
        .state  (state),
        .hitbox (hitbox),
        .win    (win)
    );

    player_sprite_render player_sprite_render_inst (
        .Clk       (Clk),
        .reset     (reset),
        .state     (state),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .rom_data  (rom_data),
        .rom_addr  (rom_addr),
        .bank      (bank),
        .in_sprite (in_sprite),
        .pixel     (pixel)
    );

    // enum bit is the bank select
    sprite_rom sprite_rom_inst (
        .Clk      (Clk),
        .rom_addr (rom_addr),
        .bank     (bank == player_pkg::RUN),
        .rom_data (rom_data)
    );

endmodule

// ==== sprite_rom.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module sprite_rom (
    input  logic                Clk,
    input  logic [`ROM_AW-1:0]  rom_addr,
    // 1 selects the run bank, 0 the idle bank
    input  logic                bank,
    output logic [`PIX_W-1:0]   rom_data
);

    // one array per animation type
    logic [`PIX_W-1:0] mem_idle [0:`ROM_DEPTH-1];
    logic [`PIX_W-1:0] mem_run  [0:`ROM_DEPTH-1];

    initial begin
        $readmemh("sprite_idle.hex", mem_idle);
        $readmemh("sprite_run.hex", mem_run);
    end

    // registered read, one cycle latency
    always_ff @(posedge Clk) begin
        if (bank) begin
            rom_data <= mem_run[rom_addr];
        end else begin
            rom_data <= mem_idle[rom_addr];
        end
    end

endmodule

// ==== player_sprite_render.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module player_sprite_render (
    input  logic                      Clk,
    input  logic                      reset,
    input  player_pkg::motion_state_t state,
    input  logic [9:0]                draw_x,
    input  logic [9:0]                draw_y,
    input  logic [`PIX_W-1:0]         rom_data,
    output logic [`ROM_AW-1:0]        rom_addr,
    output player_pkg::anim_t         bank,
    output logic                      in_sprite,
    output logic [`PIX_W-1:0]         pixel
);

    localparam player_pkg::pos_t W = player_pkg::pos_t'(`SPRITE_W);
    localparam player_pkg::pos_t H = player_pkg::pos_t'(`SPRITE_H);
    localparam logic [`ROM_AW-1:0] ROW_STRIDE = `SPRITE_W;
    localparam logic [`ROM_AW-1:0] COL_LAST = `SPRITE_W - 1;

    // draw point relative to the sprite corner
    player_pkg::pos_t  off_x, off_y;
    logic              hit;
    logic [`ROM_AW-1:0] col, row;
    // hit flag lined up with the rom read
    logic              hit_q;

    always_comb begin
        off_x = player_pkg::pos_t'({6'd0, draw_x}) - state.x;
        off_y = player_pkg::pos_t'({6'd0, draw_y}) - state.y;
        hit   = (off_x >= 0) && (off_x < W) && (off_y >= 0) && (off_y < H);
        col   = off_x[`ROM_AW-1:0];
        row   = off_y[`ROM_AW-1:0];
        // mirror the column while facing left
        if (state.facing_left) begin
            col = COL_LAST - col;
        end
        // address 0 outside the box
        rom_addr = hit ? (row * ROW_STRIDE + col) : '0;
    end

    assign bank = state.anim;

    always_ff @(posedge Clk) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

    assign in_sprite = hit_q;
    // transparent outside the sprite
    assign pixel = hit_q ? rom_data : '0;

endmodule

// ==== player_status.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module player_status (
    input  player_pkg::motion_state_t state,
    output player_pkg::hitbox_t       hitbox,
    output logic                      win
);

    localparam player_pkg::pos_t TOP_OFS = player_pkg::pos_t'(`INSET_TOP);
    localparam player_pkg::pos_t BOT_OFS = player_pkg::pos_t'(`SPRITE_H - `INSET_BOTTOM);
    localparam player_pkg::pos_t LEFT_OFS = player_pkg::pos_t'(`INSET_SIDE);
    localparam player_pkg::pos_t RIGHT_OFS = player_pkg::pos_t'(`SPRITE_W - `INSET_SIDE);

    // exit square edges
    localparam player_pkg::pos_t EXIT_L = player_pkg::pos_t'(`EXIT_X - `EXIT_RADIUS);
    localparam player_pkg::pos_t EXIT_R = player_pkg::pos_t'(`EXIT_X + `EXIT_RADIUS);
    localparam player_pkg::pos_t EXIT_T = player_pkg::pos_t'(`EXIT_Y - `EXIT_RADIUS);
    localparam player_pkg::pos_t EXIT_B = player_pkg::pos_t'(`EXIT_Y + `EXIT_RADIUS);

    // sprite box pulled in by the insets
    always_comb begin
        hitbox.top    = state.y + TOP_OFS;
        hitbox.bottom = state.y + BOT_OFS;
        hitbox.left   = state.x + LEFT_OFS;
        hitbox.right  = state.x + RIGHT_OFS;
    end

    // strict overlap on all four sides
    assign win = (hitbox.right > EXIT_L) && (hitbox.left < EXIT_R) &&
                 (hitbox.bottom > EXIT_T) && (hitbox.top < EXIT_B);

endmodule

// ==== player_motion.sv ====
`timescale 1ns/1ps
`include "player_defines.svh"

module player_motion (
    input  logic                      Clk,
    input  logic                      reset,
    input  logic                      revive,
    input  logic                      dead,
    input  player_pkg::player_cmd_t   cmd,
    output player_pkg::motion_state_t state
);

    // x clamp keeps the hitbox inside the arena
    localparam player_pkg::pos_t X_LO = player_pkg::pos_t'(`ARENA_X_MIN - `INSET_SIDE);
    localparam player_pkg::pos_t X_HI =
        player_pkg::pos_t'(`ARENA_X_MAX - `SPRITE_W - 1 + `INSET_SIDE);
    localparam player_pkg::pos_t Y_TOP = player_pkg::pos_t'(`ARENA_Y_MIN);
    localparam player_pkg::pos_t Y_MAX = player_pkg::pos_t'(`ARENA_Y_MAX);
    // resting y on the floor
    localparam player_pkg::pos_t Y_FLOOR = player_pkg::pos_t'(`ARENA_Y_MAX - `SPRITE_H - 1);
    localparam player_pkg::pos_t H = player_pkg::pos_t'(`SPRITE_H);
    localparam player_pkg::pos_t WALK = player_pkg::pos_t'(`WALK_SPEED);
    localparam player_pkg::pos_t JUMP_V = player_pkg::pos_t'(`JUMP_V0);
    localparam player_pkg::pos_t GRAV = player_pkg::pos_t'(`GRAVITY_STEP);
    localparam player_pkg::pos_t START_X = player_pkg::pos_t'(`START_X);
    localparam player_pkg::pos_t START_Y = player_pkg::pos_t'(`START_Y);
    localparam int GC_W = $clog2(`GRAVITY_DIV + 1);
    localparam logic [GC_W-1:0] GC_WRAP = GC_W'(`GRAVITY_DIV);

    // position and vertical velocity
    player_pkg::pos_t x, y, vy;
    // horizontal velocity comes straight from the keys on each tick
    player_pkg::pos_t x_n, y_n, vx_n, vy_n;
    logic             grounded, grounded_n;
    logic [GC_W-1:0]  grav_cnt, grav_cnt_n;
    logic             facing_left, facing_n;
    player_pkg::anim_t anim, anim_n;

    always_ff @(posedge Clk) begin
        // revive returns the player to the start like reset
        if (reset || revive) begin
            x           <= START_X;
            y           <= START_Y;
            vy          <= '0;
            grounded    <= 1'b1;
            grav_cnt    <= '0;
            facing_left <= 1'b0;
            anim        <= player_pkg::IDLE;
        end else begin
            x           <= x_n;
            y           <= y_n;
            vy          <= vy_n;
            grounded    <= grounded_n;
            grav_cnt    <= grav_cnt_n;
            facing_left <= facing_n;
            anim        <= anim_n;
        end
    end

    always_comb begin
        // hold everything between ticks
        x_n        = x;
        y_n        = y;
        vx_n       = '0;
        vy_n       = vy;
        grounded_n = grounded;
        grav_cnt_n = grav_cnt;
        facing_n   = facing_left;
        anim_n     = anim;

        // frozen while dead
        if (cmd.tick && !dead) begin
            // left wins over right
            if (cmd.left) begin
                vx_n = -WALK;
            end else if (cmd.right) begin
                vx_n = WALK;
            end else begin
                vx_n = '0;
            end

            // gravity only every sixth tick
            grav_cnt_n = grav_cnt + 1'b1;
            if (grav_cnt == GC_WRAP) begin
                grav_cnt_n = '0;
                vy_n       = vy + GRAV;
            end

            // jump overrides the gravity step
            if (cmd.jump && grounded) begin
                vy_n       = JUMP_V;
                grounded_n = 1'b0;
            end

            x_n = x + vx_n;
            y_n = y + vy_n;

            // horizontal arena walls
            if (x_n < X_LO) begin
                x_n = X_LO;
            end else if (x_n > X_HI) begin
                x_n = X_HI;
            end

            // ceiling stops the rise and floor lands the player
            if (y_n < Y_TOP) begin
                y_n  = Y_TOP;
                vy_n = '0;
            end else if (y_n + H >= Y_MAX) begin
                y_n        = Y_FLOOR;
                grounded_n = 1'b1;
                vy_n       = '0;
            end

            anim_n = (vx_n != '0) ? player_pkg::RUN : player_pkg::IDLE;

            // facing follows the last nonzero direction
            if (vx_n < 0) begin
                facing_n = 1'b1;
            end else if (vx_n > 0) begin
                facing_n = 1'b0;
            end
        end
    end

    assign state = '{x: x, y: y, facing_left: facing_left, anim: anim};

endmodule

// ==== player_input_decode.sv ====
`timescale 1ns/1ps

module player_input_decode (
    input  logic                    Clk,
    input  logic                    reset,
    input  logic                    frame_clk,
    input  logic                    dead,
    input  logic                    key_jump,
    input  logic                    key_left,
    input  logic                    key_right,
    output player_pkg::player_cmd_t cmd
);

    // two-stage sampler of the slow frame clock
    logic frame_s1;
    logic frame_s2;
    // registered rising-edge pulse
    logic tick_q;

    always_ff @(posedge Clk) begin
        if (reset) begin
            frame_s1 <= 1'b0;
            frame_s2 <= 1'b0;
            tick_q   <= 1'b0;
        end else begin
            frame_s1 <= frame_clk;
            frame_s2 <= frame_s1;
            // high for one cycle after the first high sample
            tick_q   <= frame_s1 && !frame_s2;
        end
    end

    // keys pass straight through, forced low while dead
    always_comb begin
        cmd.tick  = tick_q;
        cmd.jump  = key_jump && !dead;
        cmd.left  = key_left && !dead;
        cmd.right = key_right && !dead;
    end

endmodule

// ==== player_pkg.sv ====
package player_pkg;

    // signed screen coordinate or velocity
    typedef logic signed [15:0] pos_t;

    // animation type, also the sprite bank select
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } anim_t;

    // decoded per-cycle command
    typedef struct packed {
        // one-cycle frame tick
        logic tick;
        // key levels, already masked while dead
        logic jump;
        logic left;
        logic right;
    } player_cmd_t;

    // registered visible state
    typedef struct packed {
        pos_t  x;
        pos_t  y;
        logic  facing_left;
        anim_t anim;
    } motion_state_t;

    // inset collision box
    typedef struct packed {
        pos_t top;
        pos_t bottom;
        pos_t left;
        pos_t right;
    } hitbox_t;

endpackage

// ==== player_defines.svh ====
`ifndef PLAYER_DEFINES_SVH
`define PLAYER_DEFINES_SVH

// sprite size in pixels
`define SPRITE_W 8
`define SPRITE_H 12

// fixed arena bounds, screen coordinates
`define ARENA_X_MIN 0
`define ARENA_X_MAX 640
`define ARENA_Y_MIN 0
`define ARENA_Y_MAX 480

// start point, sprite standing on the floor
`define START_X 32
`define START_Y 467

// per-tick speeds
`define WALK_SPEED 2
`define JUMP_V0 (-7)
`define GRAVITY_STEP 1
// gravity counter wraps after this value
`define GRAVITY_DIV 5

// exit square centre and half-size
`define EXIT_X 96
`define EXIT_Y 472
`define EXIT_RADIUS 16

// hitbox insets from the sprite edges
`define INSET_TOP 2
`define INSET_BOTTOM 1
`define INSET_SIDE 1

// sprite rom geometry
`define ROM_DEPTH 96
`define ROM_AW 7
`define PIX_W 8

`endif
